// ==== src/translationUnit_params.svh ====
`ifndef TRANSLATIONUNIT_PARAMS_SVH
`define TRANSLATIONUNIT_PARAMS_SVH

////////////////////////////////////////
// Translation buffers
////////////////////////////////////////

// Entries in each of the two fully associative TLBs
`define TLB_ENTRIES 4

////////////////////////////////////////
// Address and data widths
////////////////////////////////////////

// Virtual page number, physical page number and page offset
`define VPN_BITS 8
`define PPN_BITS 12
`define OFFSET_BITS 12

// Data words and page-table entries share this width
`define DATA_BITS 32

// Physical base of the single-level page table
// Entry v sits at PT_BASE + 4*v
`define PT_BASE 24'hF0_0000

`endif

// ==== src/walkCtrlPkg.sv ====
`default_nettype none

package walkCtrlPkg;

   // Opcode carried on the memory port and in the CPU request
   typedef enum logic {
      memRead,
      memWrite
   } memOpE;

   // Interlock states, following the six-state graph of the core
   typedef enum logic [2:0] {
      lockReady,
      lockReplay,
      lockDtlbMiss,
      lockItlbMiss,
      lockItlbMissWithData,
      lockBothMiss
   } interlockStateE;

   // Page-table walker, one read per walk
   typedef enum logic [1:0] {
      walkIdle,
      walkRequest,
      walkRelease,
      walkFill
   } walkStateE;

   // CPU access port, from start through acknowledge
   typedef enum logic [1:0] {
      accessIdle,
      accessIssue,
      accessRelease,
      accessDone
   } accessStateE;

endpackage

`default_nettype wire

// ==== src/vmTypesPkg.sv ====
`default_nettype none

`include "translationUnit_params.svh"

package vmTypesPkg;

   ////////////////////////////////////////
   // Addresses and page-table entries
   ////////////////////////////////////////

   typedef struct packed {
      logic [`VPN_BITS-1:0]    vpn;
      logic [`OFFSET_BITS-1:0] offset;
   } virtAddrT;

   typedef struct packed {
      logic [`PPN_BITS-1:0]    ppn;
      logic [`OFFSET_BITS-1:0] offset;
   } physAddrT;

   // Only the low bits carry the page number, every entry is valid
   typedef struct packed {
      logic [`DATA_BITS-`PPN_BITS-1:0] reserved;
      logic [`PPN_BITS-1:0]            ppn;
   } pteT;

   ////////////////////////////////////////
   // Port bundles
   ////////////////////////////////////////

   // One fetch plus an optional data access, held stable under cpuReq
   typedef struct packed {
      virtAddrT              fetchVa;
      logic                  dataValid;
      walkCtrlPkg::memOpE    op;
      virtAddrT              dataVa;
      logic [`DATA_BITS-1:0] wdata;
      logic                  trap;
   } cpuReqT;

   typedef struct packed {
      physAddrT              fetchPa;
      logic [`DATA_BITS-1:0] rdata;
   } cpuRespT;

   typedef struct packed {
      walkCtrlPkg::memOpE    op;
      physAddrT              addr;
      logic [`DATA_BITS-1:0] wdata;
   } memCmdT;

   typedef struct packed {
      logic [`VPN_BITS-1:0] vpn;
      logic [`PPN_BITS-1:0] ppn;
   } tlbFillT;

endpackage

`default_nettype wire

// ==== src/tlb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "translationUnit_params.svh"

module tlb (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`VPN_BITS-1:0] lookupVpn,
   input  logic                 lookupValid,
   input  vmTypesPkg::tlbFillT  fill,
   input  logic                 fillWrite,
   output logic                 hit,
   output logic                 miss,
   output logic [`PPN_BITS-1:0] ppn
);

   localparam int PtrBits = (`TLB_ENTRIES > 1) ? $clog2(`TLB_ENTRIES) : 1;

   logic [`TLB_ENTRIES-1:0] entryValid;
   logic [`VPN_BITS-1:0]    entryTag [`TLB_ENTRIES];
   logic [`PPN_BITS-1:0]    entryPpn [`TLB_ENTRIES];
   logic [PtrBits-1:0]      victim;
   logic [`TLB_ENTRIES-1:0] match;

   ////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////

   // All entries are compared at once
   // A page is never loaded twice, so at most one match is set and an OR picks its data
   always_comb begin
      ppn = '0;
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
         match[i] = entryValid[i] & (entryTag[i] == lookupVpn);
         if (match[i]) begin
            ppn = ppn | entryPpn[i];
         end
      end
   end

   assign hit  = lookupValid & (|match);
   assign miss = lookupValid & ~(|match);

   ////////////////////////////////////////
   // Refill
   ////////////////////////////////////////

   // The victim pointer walks the entries in order, so the oldest fill goes first
   always_ff @(posedge clk) begin
      if (reset) begin
         entryValid <= '0;
         victim     <= '0;
      end else if (fillWrite) begin
         entryValid[victim] <= 1'b1;
         if (victim == PtrBits'(`TLB_ENTRIES - 1)) begin
            victim <= '0;
         end else begin
            victim <= victim + 1'b1;
         end
      end
   end

   // Tag and page number of the victim entry
   always_ff @(posedge clk) begin
      if (fillWrite) begin
         entryTag[victim] <= fill.vpn;
         entryPpn[victim] <= fill.ppn;
      end
   end

endmodule

`default_nettype wire

// ==== src/interlockFsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module interlockFsm (
   input  logic clk,
   input  logic reset,
   input  logic itlbMiss,
   input  logic itlbFill,
   input  logic dtlbMiss,
   input  logic dtlbFill,
   input  logic dataRequested,
   input  logic trap,
   input  logic accessBusy,
   output logic interlockStall,
   output logic selWalker,
   output logic replayAccess,
   output logic ignoreRequest
);

   walkCtrlPkg::interlockStateE state;
   walkCtrlPkg::interlockStateE nextState;
   logic                        inReady;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= walkCtrlPkg::lockReady;
      end else begin
         state <= nextState;
      end
   end

   ////////////////////////////////////////
   // Transition graph
   ////////////////////////////////////////

   always_comb begin
      nextState = state;
      case (state)
         // The two miss reports are combined here into one walk order
         walkCtrlPkg::lockReady: begin
            if (!itlbMiss && dtlbMiss && dataRequested) begin
               nextState = walkCtrlPkg::lockDtlbMiss;
            end else if (itlbMiss && !dtlbMiss && !dataRequested) begin
               nextState = walkCtrlPkg::lockItlbMiss;
            end else if (itlbMiss && !dtlbMiss && dataRequested) begin
               nextState = walkCtrlPkg::lockItlbMissWithData;
            end else if (itlbMiss && dtlbMiss && dataRequested) begin
               nextState = walkCtrlPkg::lockBothMiss;
            end
         end
         // Held while the translated access runs on the memory port
         walkCtrlPkg::lockReplay: begin
            if (!accessBusy) begin
               nextState = walkCtrlPkg::lockReady;
            end
         end
         walkCtrlPkg::lockDtlbMiss: begin
            if (dtlbFill) begin
               nextState = walkCtrlPkg::lockReplay;
            end
         end
         // A fetch alone needs no replay, the next lookup simply hits
         walkCtrlPkg::lockItlbMiss: begin
            if (itlbFill) begin
               nextState = walkCtrlPkg::lockReady;
            end
         end
         walkCtrlPkg::lockItlbMissWithData: begin
            if (itlbFill) begin
               nextState = walkCtrlPkg::lockReplay;
            end
         end
         // Data page first, then the fetch page
         walkCtrlPkg::lockBothMiss: begin
            if (dtlbFill) begin
               nextState = walkCtrlPkg::lockItlbMissWithData;
            end
         end
         default: nextState = walkCtrlPkg::lockReady;
      endcase
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   assign inReady = (state == walkCtrlPkg::lockReady);

   // The walker owns the memory port in every miss state
   assign selWalker = (state == walkCtrlPkg::lockDtlbMiss) |
                      (state == walkCtrlPkg::lockItlbMiss) |
                      (state == walkCtrlPkg::lockItlbMissWithData) |
                      (state == walkCtrlPkg::lockBothMiss);

   // A fresh miss stalls the CPU in the same cycle it is seen
   assign interlockStall = selWalker | (inReady & (itlbMiss | dtlbMiss));

   assign replayAccess = (nextState == walkCtrlPkg::lockReplay);

   // Trap cancels the access whether it is fresh or being replayed
   assign ignoreRequest = (inReady & (itlbMiss | dtlbMiss | trap)) |
                          ((state == walkCtrlPkg::lockReplay) & trap);

endmodule

`default_nettype wire

// ==== src/pageTableWalker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "translationUnit_params.svh"

module pageTableWalker (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 selWalker,
   input  logic                 itlbMiss,
   input  logic                 dtlbMiss,
   input  logic [`VPN_BITS-1:0] fetchVpn,
   input  logic [`VPN_BITS-1:0] dataVpn,
   output vmTypesPkg::memCmdT   walkCmd,
   output logic                 walkReq,
   input  logic                 memAck,
   input  vmTypesPkg::pteT      memRdata,
   output vmTypesPkg::tlbFillT  fill,
   output logic                 itlbFill,
   output logic                 dtlbFill
);

   walkCtrlPkg::walkStateE state;
   logic                   startWalk;
   logic                   walkData;
   logic [`VPN_BITS-1:0]   walkVpn;
   vmTypesPkg::pteT        pte;

   // A walk is only started from idle, and idle always follows the single fill cycle
   // So a fill can never be pending when a new walk begins
   assign startWalk = selWalker & (itlbMiss | dtlbMiss);

   ////////////////////////////////////////
   // Walk sequence
   ////////////////////////////////////////

   // Request and release follow the four phases of the memory port
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= walkCtrlPkg::walkIdle;
         walkReq <= 1'b0;
      end else begin
         case (state)
            walkCtrlPkg::walkIdle: begin
               if (startWalk) begin
                  walkReq <= 1'b1;
                  state   <= walkCtrlPkg::walkRequest;
               end
            end
            walkCtrlPkg::walkRequest: begin
               if (memAck) begin
                  walkReq <= 1'b0;
                  state   <= walkCtrlPkg::walkRelease;
               end
            end
            // Wait for memAck to fall before the fill, the port is then free
            walkCtrlPkg::walkRelease: begin
               if (!memAck) begin
                  state <= walkCtrlPkg::walkFill;
               end
            end
            walkCtrlPkg::walkFill: begin
               state <= walkCtrlPkg::walkIdle;
            end
            default: state <= walkCtrlPkg::walkIdle;
         endcase
      end
   end

   // The data page wins when both TLBs missed
   always_ff @(posedge clk) begin
      if (state == walkCtrlPkg::walkIdle && startWalk) begin
         walkData <= dtlbMiss;
         walkVpn  <= dtlbMiss ? dataVpn : fetchVpn;
      end
      // Entry is taken while memRdata is valid under memAck
      if (state == walkCtrlPkg::walkRequest && memAck) begin
         pte <= memRdata;
      end
   end

   ////////////////////////////////////////
   // Memory command and refill
   ////////////////////////////////////////

   // Single-level table, one word per virtual page
   assign walkCmd.op    = walkCtrlPkg::memRead;
   assign walkCmd.addr  = `PT_BASE + {walkVpn, 2'b00};
   assign walkCmd.wdata = '0;

   assign fill.vpn = walkVpn;
   assign fill.ppn = pte.ppn;

   // One-cycle strobe into the TLB that missed
   assign itlbFill = (state == walkCtrlPkg::walkFill) & ~walkData;
   assign dtlbFill = (state == walkCtrlPkg::walkFill) & walkData;

endmodule

`default_nettype wire

// ==== src/cpuAccessPort.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "translationUnit_params.svh"

module cpuAccessPort (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cpuReq,
   input  vmTypesPkg::cpuReqT    req,
   input  logic [`PPN_BITS-1:0]  fetchPpn,
   input  logic [`PPN_BITS-1:0]  dataPpn,
   input  logic                  interlockStall,
   input  logic                  replayAccess,
   input  logic                  ignoreRequest,
   input  logic                  selWalker,
   input  vmTypesPkg::memCmdT    walkCmd,
   input  logic                  walkReq,
   output vmTypesPkg::memCmdT    memCmd,
   output logic                  memReq,
   input  logic                  memAck,
   input  logic [`DATA_BITS-1:0] memRdata,
   output logic                  accessBusy,
   output logic                  cpuAck,
   output vmTypesPkg::cpuRespT   cpuResp
);

   walkCtrlPkg::accessStateE state;
   vmTypesPkg::memCmdT       accessCmd;
   logic                     accessReq;
   logic                     skipMemory;

   // Trapped, or fetch only
   assign skipMemory = ignoreRequest | ~req.dataValid;

   ////////////////////////////////////////
   // CPU handshake and data access
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= walkCtrlPkg::accessIdle;
         accessReq <= 1'b0;
         cpuAck    <= 1'b0;
      end else begin
         case (state)
            // Replay lets the access start in the cycle the last fill lands
            walkCtrlPkg::accessIdle: begin
               if (cpuReq && (!interlockStall || replayAccess)) begin
                  state <= walkCtrlPkg::accessIssue;
               end
            end
            walkCtrlPkg::accessIssue: begin
               if (!accessReq) begin
                  if (skipMemory) begin
                     cpuAck <= 1'b1;
                     state  <= walkCtrlPkg::accessDone;
                  end else begin
                     accessReq <= 1'b1;
                  end
               end else if (memAck) begin
                  accessReq <= 1'b0;
                  state     <= walkCtrlPkg::accessRelease;
               end
            end
            walkCtrlPkg::accessRelease: begin
               if (!memAck) begin
                  cpuAck <= 1'b1;
                  state  <= walkCtrlPkg::accessDone;
               end
            end
            // cpuAck stays up until the CPU lets go of cpuReq
            walkCtrlPkg::accessDone: begin
               if (!cpuReq) begin
                  cpuAck <= 1'b0;
                  state  <= walkCtrlPkg::accessIdle;
               end
            end
            default: state <= walkCtrlPkg::accessIdle;
         endcase
      end
   end

   // Both TLBs hit during issue, so the fetch address is final there
   always_ff @(posedge clk) begin
      if (state == walkCtrlPkg::accessIssue) begin
         cpuResp.fetchPa <= {fetchPpn, req.fetchVa.offset};
         if (!accessReq) begin
            cpuResp.rdata <= '0;
         end else if (memAck && req.op == walkCtrlPkg::memRead) begin
            cpuResp.rdata <= memRdata;
         end
      end
   end

   assign accessBusy = (state == walkCtrlPkg::accessIssue) |
                       (state == walkCtrlPkg::accessRelease);

   ////////////////////////////////////////
   // Memory port select
   ////////////////////////////////////////

   assign accessCmd.op    = req.op;
   assign accessCmd.addr  = {dataPpn, req.dataVa.offset};
   assign accessCmd.wdata = req.wdata;

   // The walker owns the port for the whole miss state
   assign memReq = selWalker ? walkReq : accessReq;
   assign memCmd = selWalker ? walkCmd : accessCmd;

endmodule

`default_nettype wire

// ==== src/translationUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "translationUnit_params.svh"

module translationUnit (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cpuReq,
   input  vmTypesPkg::cpuReqT    req,
   output logic                  cpuAck,
   output vmTypesPkg::cpuRespT   cpuResp,
   output logic                  memReq,
   output vmTypesPkg::memCmdT    memCmd,
   input  logic                  memAck,
   input  logic [`DATA_BITS-1:0] memRdata
);

   logic                 itlbLookup;
   logic                 dtlbLookup;
   logic                 itlbMiss;
   logic                 dtlbMiss;
   logic [`PPN_BITS-1:0] itlbPpn;
   logic [`PPN_BITS-1:0] dtlbPpn;
   vmTypesPkg::tlbFillT  walkFill;
   logic                 itlbFill;
   logic                 dtlbFill;
   logic                 interlockStall;
   logic                 selWalker;
   logic                 replayAccess;
   logic                 ignoreRequest;
   logic                 accessBusy;
   vmTypesPkg::memCmdT   walkCmd;
   logic                 walkReq;

   // Lookups run while a request is open, the data side only with a data access
   assign itlbLookup = cpuReq & ~cpuAck;
   assign dtlbLookup = cpuReq & ~cpuAck & req.dataValid;

   ////////////////////////////////////////
   // Side-by-side TLBs
   ////////////////////////////////////////

   tlb itlb (
      .clk         (clk),
      .reset       (reset),
      .lookupVpn   (req.fetchVa.vpn),
      .lookupValid (itlbLookup),
      .fill        (walkFill),
      .fillWrite   (itlbFill),
      .hit         (),
      .miss        (itlbMiss),
      .ppn         (itlbPpn)
   );

   tlb dtlb (
      .clk         (clk),
      .reset       (reset),
      .lookupVpn   (req.dataVa.vpn),
      .lookupValid (dtlbLookup),
      .fill        (walkFill),
      .fillWrite   (dtlbFill),
      .hit         (),
      .miss        (dtlbMiss),
      .ppn         (dtlbPpn)
   );

   ////////////////////////////////////////
   // Interlock, walker, access port
   ////////////////////////////////////////

   interlockFsm i_interlockFsm (
      .clk            (clk),
      .reset          (reset),
      .itlbMiss       (itlbMiss),
      .itlbFill       (itlbFill),
      .dtlbMiss       (dtlbMiss),
      .dtlbFill       (dtlbFill),
      .dataRequested  (req.dataValid),
      .trap           (req.trap),
      .accessBusy     (accessBusy),
      .interlockStall (interlockStall),
      .selWalker      (selWalker),
      .replayAccess   (replayAccess),
      .ignoreRequest  (ignoreRequest)
   );

   pageTableWalker i_pageTableWalker (
      .clk       (clk),
      .reset     (reset),
      .selWalker (selWalker),
      .itlbMiss  (itlbMiss),
      .dtlbMiss  (dtlbMiss),
      .fetchVpn  (req.fetchVa.vpn),
      .dataVpn   (req.dataVa.vpn),
      .walkCmd   (walkCmd),
      .walkReq   (walkReq),
      .memAck    (memAck),
      .memRdata  (memRdata),
      .fill      (walkFill),
      .itlbFill  (itlbFill),
      .dtlbFill  (dtlbFill)
   );

   cpuAccessPort i_cpuAccessPort (
      .clk            (clk),
      .reset          (reset),
      .cpuReq         (cpuReq),
      .req            (req),
      .fetchPpn       (itlbPpn),
      .dataPpn        (dtlbPpn),
      .interlockStall (interlockStall),
      .replayAccess   (replayAccess),
      .ignoreRequest  (ignoreRequest),
      .selWalker      (selWalker),
      .walkCmd        (walkCmd),
      .walkReq        (walkReq),
      .memCmd         (memCmd),
      .memReq         (memReq),
      .memAck         (memAck),
      .memRdata       (memRdata),
      .accessBusy     (accessBusy),
      .cpuAck         (cpuAck),
      .cpuResp        (cpuResp)
   );

endmodule

`default_nettype wire

// ==== dv/translationUnit_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module translationUnitAsserts (
   input logic                        clk,
   input logic                        reset,
   input logic                        cpuReq,
   input logic                        cpuAck,
   input logic                        memReq,
   input vmTypesPkg::memCmdT          memCmd,
   input logic                        itlbMiss,
   input logic                        dtlbMiss,
   input logic                        selWalker,
   input logic                        interlockStall,
   input walkCtrlPkg::interlockStateE lockState
);

   // Count of failed assertions
   int failures = 0;

   // The command may only change once memReq has dropped
   cmdStable: assert property (@(posedge clk) disable iff (reset)
      (memReq && $past(memReq)) |-> $stable(memCmd))
      else begin
         $error("memCmd changed while memReq was high");
         failures++;
      end

   // An acknowledge always answers an open request
   ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
      $rose(cpuAck) |-> cpuReq)
      else begin
         $error("cpuAck rose without cpuReq");
         failures++;
      end

   // Ready without a miss stays in ready, so the walker never takes the port
   // and a stall in the next cycle can only come from a fresh miss
   readyNoStall: assert property (@(posedge clk) disable iff (reset)
      (lockState == walkCtrlPkg::lockReady && !itlbMiss && !dtlbMiss)
         |=> (!selWalker && (!interlockStall || itlbMiss || dtlbMiss)))
      else begin
         $error("walker selected or stall raised after ready without a miss");
         failures++;
      end

endmodule

bind translationUnit translationUnitAsserts i_asserts (
   .clk            (clk),
   .reset          (reset),
   .cpuReq         (cpuReq),
   .cpuAck         (cpuAck),
   .memReq         (memReq),
   .memCmd         (memCmd),
   .itlbMiss       (itlbMiss),
   .dtlbMiss       (dtlbMiss),
   .selWalker      (selWalker),
   .interlockStall (interlockStall),
   .lockState      (i_interlockFsm.state)
);

`default_nettype wire

// ==== dv/translationChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "translationUnit_params.svh"

module translationChecker (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cpuReq,
   input  vmTypesPkg::cpuReqT    req,
   input  logic                  cpuAck,
   input  vmTypesPkg::cpuRespT   cpuResp,
   input  logic                  memReq,
   input  vmTypesPkg::memCmdT    memCmd,
   input  logic [127:0]          caseName,
   input  logic [23:0]           expFetchPa,
   input  logic [`DATA_BITS-1:0] expRdata,
   input  int                    expPtReads,
   output int                    testsDone,
   output int                    errorCount
);

   int   ptReads;
   int   caseErrors;
   logic reqQ;
   logic ackQ;
   logic memReqQ;

   ////////////////////////////////////////
   // Port monitor
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (reset) begin
         ptReads    = 0;
         testsDone  = 0;
         errorCount = 0;
         reqQ       = 1'b0;
         ackQ       = 1'b0;
         memReqQ    = 1'b0;
      end else begin
         // A new request starts a fresh walk count
         if (cpuReq && !reqQ) begin
            ptReads = 0;
         end
         // Each new memory request in the table region is one walk
         if (memReq && !memReqQ) begin
            if (memCmd.addr >= `PT_BASE) begin
               ptReads = ptReads + 1;
            end
            if (memCmd.op == walkCtrlPkg::memWrite && req.trap) begin
               $display("%0s: a store reached memory although trap was set", caseName);
               errorCount = errorCount + 1;
            end
         end
         // Response is valid when cpuAck is seen high
         if (cpuAck && !ackQ) begin
            caseErrors = 0;
            if (cpuResp.fetchPa !== expFetchPa) begin
               $display("[ERROR] %0s fetchPa expected %h actual %h",
                        caseName, expFetchPa, cpuResp.fetchPa);
               caseErrors = caseErrors + 1;
            end
            if (cpuResp.rdata !== expRdata) begin
               $display("[ERROR] %0s rdata expected %h actual %h",
                        caseName, expRdata, cpuResp.rdata);
               caseErrors = caseErrors + 1;
            end
            if (ptReads != expPtReads) begin
               $display("[ERROR] %0s page-table reads expected %0d actual %0d",
                        caseName, expPtReads, ptReads);
               caseErrors = caseErrors + 1;
            end
            $display("%0s finished with %0d mismatches", caseName, caseErrors);
            errorCount = errorCount + caseErrors;
            testsDone  = testsDone + 1;
         end
         reqQ    = cpuReq;
         ackQ    = cpuAck;
         memReqQ = memReq;
      end
   end

endmodule

`default_nettype wire

// ==== dv/tbTranslationUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "translationUnit_params.svh"

module tbTranslationUnit;

   localparam int MaxCases = 64;

   logic                  clk;
   logic                  reset;
   logic                  cpuReq;
   vmTypesPkg::cpuReqT    req;
   logic                  cpuAck;
   vmTypesPkg::cpuRespT   cpuResp;
   logic                  memReq;
   vmTypesPkg::memCmdT    memCmd;
   logic                  memAck;
   logic [`DATA_BITS-1:0] memRdata;

   logic [127:0]          caseName;
   logic [23:0]           expFetchPa;
   logic [`DATA_BITS-1:0] expRdata;
   int                    expPtReads;
   int                    testsDone;
   int                    errorCount;

   // Case table, filled from the data file
   logic [127:0]          names [MaxCases];
   vmTypesPkg::cpuReqT    stim [MaxCases];
   logic [23:0]           fetchPas [MaxCases];
   logic [`DATA_BITS-1:0] rdatas [MaxCases];
   int                    ptCounts [MaxCases];
   int                    numCases;
   logic                  casesLoaded;

   integer                seed;
   logic [`DATA_BITS-1:0] dataMem [int];

   translationUnit i_dut (
      .clk      (clk),
      .reset    (reset),
      .cpuReq   (cpuReq),
      .req      (req),
      .cpuAck   (cpuAck),
      .cpuResp  (cpuResp),
      .memReq   (memReq),
      .memCmd   (memCmd),
      .memAck   (memAck),
      .memRdata (memRdata)
   );

   translationChecker i_checker (
      .clk        (clk),
      .reset      (reset),
      .cpuReq     (cpuReq),
      .req        (req),
      .cpuAck     (cpuAck),
      .cpuResp    (cpuResp),
      .memReq     (memReq),
      .memCmd     (memCmd),
      .caseName   (caseName),
      .expFetchPa (expFetchPa),
      .expRdata   (expRdata),
      .expPtReads (expPtReads),
      .testsDone  (testsDone),
      .errorCount (errorCount)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////
   // Case file
   ////////////////////////////////////////

   task automatic loadCases();
      int         fd;
      int         got;
      string      line;
      logic [127:0] nm;
      logic [19:0] fva;
      logic [19:0] dva;
      logic [31:0] wd;
      logic [31:0] rd;
      logic [23:0] pa;
      logic       dv;
      logic       op;
      logic       tr;
      int         pt;
      fd = $fopen("dv/translation_cases.txt", "r");
      if (fd == 0) begin
         $display("The case file dv/translation_cases.txt could not be opened");
      end else begin
         while (!$feof(fd) && numCases < MaxCases) begin
            line = "";
            void'($fgets(line, fd));
            // Skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
               got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d",
                             nm, fva, dv, op, dva, wd, tr, pa, rd, pt);
               if (got == 10) begin
                  names[numCases]             = nm;
                  stim[numCases].fetchVa      = fva;
                  stim[numCases].dataValid    = dv;
                  stim[numCases].op           = walkCtrlPkg::memOpE'(op);
                  stim[numCases].dataVa       = dva;
                  stim[numCases].wdata        = wd;
                  stim[numCases].trap         = tr;
                  fetchPas[numCases]          = pa;
                  rdatas[numCases]            = rd;
                  ptCounts[numCases]          = pt;
                  numCases = numCases + 1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////
   // CPU driver
   ////////////////////////////////////////

   task automatic runCase(input int idx);
      @(posedge clk);
      caseName   <= names[idx];
      expFetchPa <= fetchPas[idx];
      expRdata   <= rdatas[idx];
      expPtReads <= ptCounts[idx];
      req        <= stim[idx];
      cpuReq     <= 1'b1;
      // Hold the request until the DUT answers
      @(posedge clk);
      while (!cpuAck) @(posedge clk);
      cpuReq <= 1'b0;
      @(posedge clk);
      while (cpuAck) @(posedge clk);
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      cpuReq      = 1'b0;
      req         = '0;
      memAck      = 1'b0;
      memRdata    = '0;
      caseName    = '0;
      expFetchPa  = '0;
      expRdata    = '0;
      expPtReads  = 0;
      numCases    = 0;
      casesLoaded = 1'b0;
      seed        = 32'h0cd7_1bde;
      loadCases();
      casesLoaded = 1'b1;
      if (numCases == 0) begin
         $display("No test cases were read, so nothing could be checked");
         $display("TB FAILED");
      end else begin
         repeat (16) @(posedge clk);
         reset <= 1'b0;
         for (int i = 0; i < numCases; i++) begin
            runCase(i);
         end
         repeat (4) @(posedge clk);
         $display("Tests run: %0d of %0d, errors: %0d, assertion failures: %0d",
                  testsDone, numCases, errorCount, i_dut.i_asserts.failures);
         if (errorCount == 0 && i_dut.i_asserts.failures == 0 &&
             testsDone == numCases) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
      end
      $finish;
   end

   ////////////////////////////////////////
   // Memory responder
   ////////////////////////////////////////

   // Waits a random 0 to 3 cycles before each edge of memAck
   task automatic randomDelay();
      int cycles;
      cycles = $unsigned($random(seed)) % 4;
      repeat (cycles) @(posedge clk);
   endtask

   function automatic logic [`DATA_BITS-1:0] answerRead(input logic [23:0] addr);
      logic [23:0] vpn;
      if (addr >= `PT_BASE) begin
         vpn = (addr - `PT_BASE) >> 2;
         return 32'((vpn * 37 + 11) % 4096);
      end else if (dataMem.exists(int'(addr))) begin
         return dataMem[int'(addr)];
      end else begin
         return 32'(addr);
      end
   endfunction

   initial begin
      @(negedge reset);
      forever begin
         @(posedge clk);
         if (memReq) begin
            randomDelay();
            if (memCmd.op == walkCtrlPkg::memWrite) begin
               dataMem[int'(memCmd.addr)] = memCmd.wdata;
               memRdata <= '0;
            end else begin
               memRdata <= answerRead(memCmd.addr);
            end
            memAck <= 1'b1;
            @(posedge clk);
            while (memReq) @(posedge clk);
            randomDelay();
            memAck <= 1'b0;
            @(posedge clk);
         end
      end
   end

   ////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////

   initial begin
      wait (casesLoaded);
      repeat (16 + numCases * 200) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", 16 + numCases * 200);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== translationUnit.f ====
+incdir+src
src/walkCtrlPkg.sv
src/vmTypesPkg.sv
src/tlb.sv
src/interlockFsm.sv
src/pageTableWalker.sv
src/cpuAccessPort.sv
src/translationUnit.sv
dv/translationUnit_asserts.sv
dv/translationChecker.sv
dv/tbTranslationUnit.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tbTranslationUnit
FILELIST  ?= translationUnit.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/translation_cases.txt ====
# name fetchVa dataValid op(0 read, 1 write) dataVa wdata trap
#   expFetchPa expRdata expPtReads (all hex except the last, decimal)
fetchMissOnly    10123 0 0 00000 00000000 0 25B123 00000000 1
dataLoadMiss     10200 1 0 20040 00000000 0 25B200 004AB040 1
storeHit         10300 1 1 20080 CAFEF00D 0 25B300 00000000 0
loadAfterStore   10304 1 0 20080 00000000 0 25B304 CAFEF00D 0
bothMiss         40010 1 0 21100 00000000 0 94B010 004D0100 2
trapStore        10000 1 1 20100 12345678 1 25B000 00000000 0
trapNoWrite      10004 1 0 20100 00000000 0 25B004 004AB100 0
fillThird        10008 1 0 22000 00000000 0 25B008 004F5000 1
fillFourth       1000C 1 0 23000 00000000 0 25B00C 0051A000 1
evictOldest      10010 1 0 24000 00000000 0 25B010 0053F000 1
revisitEvicted   10014 1 0 20080 00000000 0 25B014 CAFEF00D 1
revisitKept      10018 1 0 22010 00000000 0 25B018 004F5010 0
fetchMissDataHit 41020 1 0 23004 00000000 0 970020 0051A004 1
trapDataMiss     1001C 1 0 03000 00000000 1 25B01C 00000000 1
